// ==== core_pkg.sv ====
// Shared constants and pipeline packets for the RV32I core
// Only the integer subset with word loads and stores is encoded here
`default_nettype none

package core_pkg;

  localparam int unsigned XLEN = 32;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;  // ADDI x0,x0,0

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  localparam logic [3:0] ALU_ADD  = 4'd0;
  localparam logic [3:0] ALU_SUB  = 4'd1;
  localparam logic [3:0] ALU_AND  = 4'd2;
  localparam logic [3:0] ALU_OR   = 4'd3;
  localparam logic [3:0] ALU_XOR  = 4'd4;
  localparam logic [3:0] ALU_SLL  = 4'd5;
  localparam logic [3:0] ALU_SRL  = 4'd6;
  localparam logic [3:0] ALU_SRA  = 4'd7;
  localparam logic [3:0] ALU_SLT  = 4'd8;
  localparam logic [3:0] ALU_SLTU = 4'd9;

  // Field layouts of one instruction word, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_u;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    instr_u          instr;
    logic            valid;
  } if_id_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] imm;
    logic [3:0]      alu_op;
    logic            use_imm;
    logic            use_pc;    // AUIPC takes the PC as operand a
    logic            is_branch;
    logic [2:0]      funct3;    // Branch condition select
    logic            is_jal;
    logic            is_jalr;
    logic            is_load;
    logic            is_store;
    logic            rd_en;
    logic            valid;
  } id_ex_t;

  typedef struct packed {
    logic [XLEN-1:0] alu_res;     // Also the data address
    logic [XLEN-1:0] store_data;
    logic [4:0]      rd_addr;
    logic            rd_en;
    logic            is_load;
    logic            is_store;
    logic            valid;
  } ex_mem_t;

  typedef struct packed {
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] rd_data;
    logic            rd_en;
    logic            is_load;
  } mem_wb_t;

endpackage : core_pkg

`default_nettype wire

// ==== if_stage.sv ====
// Fetch assumes a synchronous instruction memory with one cycle of latency
// The fetched PC travels alongside the returned word so the pair stays aligned
`default_nettype none

module if_stage import core_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            mem_ready,
  input  logic            redirect,
  input  logic [XLEN-1:0] redirect_pc,
  input  logic [XLEN-1:0] imem_rdata,
  output logic [XLEN-1:0] imem_addr,
  output if_id_t          if_id
);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] fetch_pc;     // Address of the word now on imem_rdata
  logic            fetch_valid;

  assign imem_addr = pc;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc          <= RESET_PC;
      fetch_pc    <= RESET_PC;
      fetch_valid <= 1'b0;
      if_id       <= '{pc: RESET_PC, instr: NOP_INSTR, valid: 1'b0};
    end else if (mem_ready) begin
      pc          <= redirect ? redirect_pc : pc + 32'd4;
      fetch_pc    <= pc;
      fetch_valid <= !redirect;  // Word for the old path is dropped
      if_id.pc    <= fetch_pc;
      if_id.instr <= redirect ? NOP_INSTR : imem_rdata;
      if_id.valid <= fetch_valid && !redirect;
    end
  end

endmodule : if_stage

`default_nettype wire

// ==== reg_file.sv ====
// Integer register file, x0 hardwired to zero
// A write in the same cycle as a read is seen by that read
`default_nettype none

module reg_file import core_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            mem_ready,
  input  logic [4:0]      rs1_addr,
  input  logic [4:0]      rs2_addr,
  input  mem_wb_t         wb,
  output logic [XLEN-1:0] rs1_data,
  output logic [XLEN-1:0] rs2_data
);

  logic [XLEN-1:0] regs [1:31];

  function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
    logic [XLEN-1:0] val;
    if (addr == 5'd0) val = '0;
    else if (wb.rd_en && wb.rd_addr == addr) val = wb.rd_data;  // Write-through
    else val = regs[addr];
    return val;
  endfunction

  // Reads also follow the array and the write-back packet
  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 1; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else if (mem_ready && wb.rd_en && wb.rd_addr != 5'd0) begin
      regs[wb.rd_addr] <= wb.rd_data;
    end
  end

endmodule : reg_file

`default_nettype wire

// ==== id_stage.sv ====
// Single-cycle decode for the supported RV32I subset
// Unknown opcodes pass through as valid no-ops with no side effects
`default_nettype none

module id_stage import core_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            mem_ready,
  input  logic            redirect,
  input  if_id_t          if_id,
  input  logic [XLEN-1:0] rs1_data,
  input  logic [XLEN-1:0] rs2_data,
  output logic [4:0]      rs1_addr,
  output logic [4:0]      rs2_addr,
  output id_ex_t          id_ex
);

  instr_u          ins;
  logic [6:0]      opcode;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  id_ex_t          dec;

  // Shared by OP and OP-IMM, alt picks SUB or SRA
  function automatic logic [3:0] alu_sel(input logic [2:0] funct3, input logic alt);
    logic [3:0] op;
    case (funct3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign ins    = if_id.instr;
  assign opcode = ins.r.opcode;

  assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
  assign imm_s = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
  assign imm_b = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11, ins.b.imm10_5,
                  ins.b.imm4_1, 1'b0};
  assign imm_u = {ins.u.imm, 12'b0};
  assign imm_j = {{11{ins.j.imm20}}, ins.j.imm20, ins.j.imm19_12, ins.j.imm11,
                  ins.j.imm10_1, 1'b0};

  assign rs1_addr = (opcode == OPC_LUI) ? 5'd0 : ins.r.rs1;  // LUI adds to x0
  assign rs2_addr = ins.r.rs2;

  always_comb begin
    dec          = '0;
    dec.pc       = if_id.pc;
    dec.rs1_addr = rs1_addr;
    dec.rs2_addr = rs2_addr;
    dec.rs1_data = rs1_data;
    dec.rs2_data = rs2_data;
    dec.rd_addr  = ins.r.rd;
    dec.funct3   = ins.r.funct3;
    dec.alu_op   = ALU_ADD;
    dec.valid    = if_id.valid;
    case (opcode)
      OPC_LUI: begin
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.rd_en   = 1'b1;
      end
      OPC_AUIPC: begin
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.use_pc  = 1'b1;
        dec.rd_en   = 1'b1;
      end
      OPC_JAL: begin
        dec.imm    = imm_j;
        dec.is_jal = 1'b1;
        dec.rd_en  = 1'b1;
      end
      OPC_JALR: begin
        dec.imm     = imm_i;
        dec.is_jalr = 1'b1;
        dec.rd_en   = 1'b1;
      end
      OPC_BRANCH: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
      end
      OPC_LOAD: begin  // Every width is treated as LW
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec.is_load = 1'b1;
        dec.rd_en   = 1'b1;
      end
      OPC_STORE: begin
        dec.imm      = imm_s;
        dec.use_imm  = 1'b1;
        dec.is_store = 1'b1;
      end
      OPC_OPIMM: begin
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec.rd_en   = 1'b1;
        dec.alu_op  = alu_sel(ins.i.funct3, ins.i.funct3 == 3'b101 && ins.r.funct7[5]);
      end
      OPC_OP: begin
        dec.rd_en  = 1'b1;
        dec.alu_op = alu_sel(ins.r.funct3, ins.r.funct7[5]);
      end
      default: ;  // No-op
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex <= '0;
    end else if (mem_ready) begin
      id_ex <= redirect ? '0 : dec;  // Wrong-path slot squashed
    end
  end

endmodule : id_stage

`default_nettype wire

// ==== ex_stage.sv ====
// Execute with forwarding from memory and write-back stages
// Loaded data is not forwarded from memory, so loads need one spacer after them
`default_nettype none

module ex_stage import core_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            mem_ready,
  input  id_ex_t          id_ex,
  input  ex_mem_t         ex_mem_fwd,
  input  mem_wb_t         wb_fwd,
  output logic            redirect,
  output logic [XLEN-1:0] redirect_pc,
  output ex_mem_t         ex_mem
);

  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_out;
  logic            taken;
  ex_mem_t         nxt;

  // Newest producer wins, x0 never forwarded
  function automatic logic [XLEN-1:0] fwd_operand(
    input logic [4:0]      addr,
    input logic [XLEN-1:0] rf_val,
    input ex_mem_t         em,
    input mem_wb_t         mw
  );
    logic [XLEN-1:0] val;
    val = rf_val;
    if (addr != 5'd0) begin
      if (em.valid && em.rd_en && em.rd_addr == addr) val = em.alu_res;
      else if (mw.rd_en && mw.rd_addr == addr) val = mw.rd_data;
    end
    return val;
  endfunction

  assign rs1_val = fwd_operand(id_ex.rs1_addr, id_ex.rs1_data, ex_mem_fwd, wb_fwd);
  assign rs2_val = fwd_operand(id_ex.rs2_addr, id_ex.rs2_data, ex_mem_fwd, wb_fwd);
  assign op_a    = id_ex.use_pc ? id_ex.pc : rs1_val;
  assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_val;

  always_comb begin
    case (id_ex.alu_op)
      ALU_SUB:  alu_out = op_a - op_b;
      ALU_AND:  alu_out = op_a & op_b;
      ALU_OR:   alu_out = op_a | op_b;
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_SLL:  alu_out = op_a << op_b[4:0];
      ALU_SRL:  alu_out = op_a >> op_b[4:0];
      ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
      ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_out = {31'b0, op_a < op_b};
      default:  alu_out = op_a + op_b;  // ALU_ADD
    endcase
  end

  always_comb begin
    case (id_ex.funct3)
      3'b000:  taken = (rs1_val == rs2_val);
      3'b001:  taken = (rs1_val != rs2_val);
      3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
      3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      3'b110:  taken = (rs1_val < rs2_val);
      3'b111:  taken = (rs1_val >= rs2_val);
      default: taken = 1'b0;
    endcase
  end

  // Not-taken prediction, so any taken control transfer redirects
  assign redirect = id_ex.valid &&
                    (id_ex.is_jal || id_ex.is_jalr || (id_ex.is_branch && taken));
  assign redirect_pc = id_ex.is_jalr ? ((rs1_val + id_ex.imm) & ~32'd1)
                                     : id_ex.pc + id_ex.imm;

  always_comb begin
    nxt.alu_res    = (id_ex.is_jal || id_ex.is_jalr) ? id_ex.pc + 32'd4 : alu_out;
    nxt.store_data = rs2_val;
    nxt.rd_addr    = id_ex.rd_addr;
    nxt.rd_en      = id_ex.valid && id_ex.rd_en;
    nxt.is_load    = id_ex.valid && id_ex.is_load;
    nxt.is_store   = id_ex.valid && id_ex.is_store;
    nxt.valid      = id_ex.valid;  // Jumps keep theirs for the link write
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem <= '0;
    end else if (mem_ready) begin
      ex_mem <= nxt;
    end
  end

endmodule : ex_stage

`default_nettype wire

// ==== mem_wb_stage.sv ====
// Data port is driven straight from the execute-to-memory register
// Load data arrives one cycle later and is picked in write-back
`default_nettype none

module mem_wb_stage import core_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            mem_ready,
  input  ex_mem_t         ex_mem,
  input  logic [XLEN-1:0] dmem_rdata,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  output logic            dmem_wr_en,
  output logic            dmem_rd_en,
  output mem_wb_t         wb
);

  mem_wb_t wb_q;

  assign dmem_addr  = ex_mem.alu_res;
  assign dmem_wdata = ex_mem.store_data;
  assign dmem_wr_en = ex_mem.valid && ex_mem.is_store;
  assign dmem_rd_en = ex_mem.valid && ex_mem.is_load;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_q <= '0;
    end else if (mem_ready) begin
      wb_q.rd_addr <= ex_mem.rd_addr;
      wb_q.rd_data <= ex_mem.alu_res;
      wb_q.rd_en   <= ex_mem.valid && ex_mem.rd_en;
      wb_q.is_load <= ex_mem.valid && ex_mem.is_load;
    end
  end

  always_comb begin
    wb = wb_q;
    if (wb_q.is_load) begin
      wb.rd_data = dmem_rdata;  // Held by memory while stalled
    end
  end

endmodule : mem_wb_stage

`default_nettype wire

// ==== riscv_core.sv ====
// Five-stage RV32I core top, one mem_ready level stalls every stage
// Both memory ports expect synchronous memories with one cycle of read latency
`default_nettype none

module riscv_core import core_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            mem_ready,
  input  logic [XLEN-1:0] imem_rdata,
  input  logic [XLEN-1:0] dmem_rdata,
  output logic [XLEN-1:0] imem_addr,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  output logic            dmem_wr_en,
  output logic            dmem_rd_en
);

  if_id_t          if_id;
  id_ex_t          id_ex;
  ex_mem_t         ex_mem;
  mem_wb_t         wb;

  logic            redirect;
  logic [XLEN-1:0] redirect_pc;

  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;

  if_stage i_if_stage (
    .clk        (clk),
    .arst_n     (arst_n),
    .mem_ready  (mem_ready),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .imem_rdata (imem_rdata),
    .imem_addr  (imem_addr),
    .if_id      (if_id)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .mem_ready(mem_ready),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wb       (wb),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  id_stage i_id_stage (
    .clk      (clk),
    .arst_n   (arst_n),
    .mem_ready(mem_ready),
    .redirect (redirect),
    .if_id    (if_id),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .id_ex    (id_ex)
  );

  ex_stage i_ex_stage (
    .clk        (clk),
    .arst_n     (arst_n),
    .mem_ready  (mem_ready),
    .id_ex      (id_ex),
    .ex_mem_fwd (ex_mem),       // Current memory-stage packet
    .wb_fwd     (wb),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .ex_mem     (ex_mem)
  );

  mem_wb_stage i_mem_wb_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_ready (mem_ready),
    .ex_mem    (ex_mem),
    .dmem_rdata(dmem_rdata),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_wr_en(dmem_wr_en),
    .dmem_rd_en(dmem_rd_en),
    .wb        (wb)
  );

endmodule : riscv_core

`default_nettype wire

// ==== riscv_core_sva.sv ====
// Memory port checks on the core, bound to every riscv_core instance
// Sampled on rising edges, so mem_ready is the level that governed each edge
`default_nettype none

module riscv_core_sva import core_pkg::*; (
  input logic            clk,
  input logic            arst_n,
  input logic            mem_ready,
  input logic [XLEN-1:0] imem_addr,
  input logic [XLEN-1:0] dmem_addr,
  input logic [XLEN-1:0] dmem_wdata,
  input logic            dmem_wr_en,
  input logic            dmem_rd_en
);
  timeunit 1ns;
  timeprecision 1ps;

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(dmem_wr_en && dmem_rd_en))
    else $error("data port read and write strobes high together");

  // Frozen pipeline keeps the data port steady
  a_hold_stalled: assert property (@(posedge clk) disable iff (!arst_n)
    !mem_ready |=> $stable(dmem_addr) && $stable(dmem_wdata) &&
                   $stable(dmem_wr_en) && $stable(dmem_rd_en))
    else $error("data port changed while mem_ready was low");

  a_fetch_align: assert property (@(posedge clk) disable iff (!arst_n)
    imem_addr[1:0] == 2'b00)
    else $error("instruction address not word aligned");

  a_quiet_after_reset: assert property (@(posedge clk)
    $rose(arst_n) |-> !dmem_wr_en && !dmem_rd_en)
    else $error("data strobe active in first cycle after reset");

endmodule : riscv_core_sva

bind riscv_core riscv_core_sva i_sva (.*);

`default_nettype wire

// ==== tb_riscv_core.sv ====
// Self-checking testbench, program built from RV32I encoders at time zero
// Memories are synchronous models driven 2 ns after each rising edge
`default_nettype none

module tb_riscv_core import core_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 16;
  localparam logic [31:0] JUNK_ADDR = 32'h3f0;  // Wrong-path stores land here

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } store_t;

  logic clk = 1'b0;
  logic arst_n = 1'b0;
  logic mem_ready = 1'b1;
  logic [31:0] imem_rdata = NOP_INSTR;
  logic [31:0] dmem_rdata = '0;
  logic [31:0] imem_addr, dmem_addr, dmem_wdata;
  logic dmem_wr_en, dmem_rd_en;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] prog [$];
  store_t exp_q [$];
  logic [31:0] saddr = 32'h100;
  integer seed = 32'hba8029db;
  int cycles = 0;
  int limit = 0;
  logic smp_ready, smp_wr, smp_rd;  // Port values captured ahead of each edge
  logic [31:0] smp_iaddr, smp_daddr, smp_wdata;

  riscv_core i_dut (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return 32'h5a5a_0000 ^ (addr * 32'h0001_0101);
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, rs1, rs2);
    instr_u w;
    w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP};
    return w;
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, rs1, input int imm);
    instr_u w;
    w.i = '{imm: imm[11:0], rs1: rs1, funct3: f3, rd: rd, opcode: opc};
    return w;
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                        input int off);
    instr_u w;
    w.b = '{imm12: off[12], imm10_5: off[10:5], rs2: rs2, rs1: rs1, funct3: f3,
            imm4_1: off[4:1], imm11: off[11], opcode: OPC_BRANCH};
    return w;
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input int off);
    instr_u w;
    w.j = '{imm20: off[20], imm10_1: off[10:1], imm11: off[11], imm19_12: off[19:12],
            rd: rd, opcode: OPC_JAL};
    return w;
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [19:0] imm);
    instr_u w;
    w.u = '{imm: imm, rd: rd, opcode: opc};
    return w;
  endfunction

  function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [11:0] off);
    instr_u w;
    w.s = '{imm_hi: off[11:5], rs2: rs2, rs1: 5'd0, funct3: 3'b010, imm_lo: off[4:0],
            opcode: OPC_STORE};
    return w;
  endfunction

  function automatic logic [31:0] cur_pc();
    return prog.size() * 4;
  endfunction

  task automatic store_expect(input logic [4:0] rs2, input logic [31:0] data);
    prog.push_back(enc_sw(rs2, saddr[11:0]));
    exp_q.push_back('{addr: saddr, data: data});
    saddr += 4;
  endtask

  // Taken path and fall-through path leave different markers in x28
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                             input int id, input logic taken);
    prog.push_back(enc_b(f3, rs1, rs2, 12));
    prog.push_back(enc_i(OPC_OPIMM, 3'b000, 5'd28, 5'd0, id));
    prog.push_back(enc_j(5'd0, 8));
    prog.push_back(enc_i(OPC_OPIMM, 3'b000, 5'd28, 5'd0, id + 100));
    store_expect(5'd28, taken ? id + 100 : id);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic build_program();
    logic [31:0] p;
    prog.push_back(enc_i(OPC_OPIMM, 3'b000, 5'd1, 5'd0, 5));       // Dependent ALU chain
    prog.push_back(enc_i(OPC_OPIMM, 3'b000, 5'd2, 5'd1, 7));
    prog.push_back(enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    prog.push_back(enc_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));       // x1 via write-through
    store_expect(5'd3, 32'd17);
    store_expect(5'd4, 32'd12);
    prog.push_back(enc_i(OPC_OPIMM, 3'b100, 5'd5, 5'd4, 32'hff));
    store_expect(5'd5, 32'hf3);
    prog.push_back(enc_r(7'h00, 3'b111, 5'd6, 5'd5, 5'd3));
    store_expect(5'd6, 32'h11);
    prog.push_back(enc_r(7'h00, 3'b110, 5'd7, 5'd6, 5'd4));
    prog.push_back(enc_r(7'h00, 3'b001, 5'd8, 5'd7, 5'd1));
    store_expect(5'd8, 32'h3a0);
    prog.push_back(enc_i(OPC_OPIMM, 3'b000, 5'd9, 5'd0, -16));
    prog.push_back(enc_r(7'h20, 3'b101, 5'd10, 5'd9, 5'd1));
    store_expect(5'd10, 32'hffff_ffff);
    prog.push_back(enc_r(7'h00, 3'b101, 5'd11, 5'd9, 5'd1));
    store_expect(5'd11, 32'h07ff_ffff);
    prog.push_back(enc_r(7'h00, 3'b010, 5'd12, 5'd9, 5'd1));
    store_expect(5'd12, 32'd1);
    prog.push_back(enc_r(7'h00, 3'b011, 5'd13, 5'd9, 5'd1));
    store_expect(5'd13, 32'd0);
    prog.push_back(enc_i(OPC_OPIMM, 3'b101, 5'd14, 5'd9, 32'h402));  // SRAI by 2
    store_expect(5'd14, 32'hffff_fffc);
    prog.push_back(enc_i(OPC_OPIMM, 3'b011, 5'd15, 5'd1, 6));
    prog.push_back(enc_i(OPC_OPIMM, 3'b111, 5'd16, 5'd9, 32'h3c));
    store_expect(5'd15, 32'd1);
    store_expect(5'd16, 32'h30);
    prog.push_back(enc_u(OPC_LUI, 5'd21, 20'h12345));
    store_expect(5'd21, 32'h1234_5000);
    p = cur_pc();
    prog.push_back(enc_u(OPC_AUIPC, 5'd22, 20'h00001));
    store_expect(5'd22, p + 32'h1000);
    prog.push_back(enc_i(OPC_OPIMM, 3'b000, 5'd23, 5'd0, 0));     // Sum 5 down to 1
    prog.push_back(enc_i(OPC_OPIMM, 3'b000, 5'd24, 5'd0, 5));
    prog.push_back(enc_r(7'h00, 3'b000, 5'd23, 5'd23, 5'd24));
    prog.push_back(enc_i(OPC_OPIMM, 3'b000, 5'd24, 5'd24, -1));
    prog.push_back(enc_b(3'b001, 5'd24, 5'd0, -8));
    store_expect(5'd23, 32'd15);
    prog.push_back(enc_i(OPC_OPIMM, 3'b000, 5'd25, 5'd0, -3));
    prog.push_back(enc_i(OPC_OPIMM, 3'b000, 5'd26, 5'd0, 4));
    prog.push_back(enc_i(OPC_OPIMM, 3'b000, 5'd27, 5'd0, 4));
    branch_case(3'b000, 5'd26, 5'd27, 1, 1'b1);   // BEQ
    branch_case(3'b000, 5'd25, 5'd26, 2, 1'b0);
    branch_case(3'b100, 5'd25, 5'd26, 3, 1'b1);   // BLT
    branch_case(3'b100, 5'd26, 5'd25, 4, 1'b0);
    branch_case(3'b101, 5'd26, 5'd25, 5, 1'b1);   // BGE
    branch_case(3'b101, 5'd25, 5'd26, 6, 1'b0);
    branch_case(3'b110, 5'd26, 5'd25, 7, 1'b1);   // BLTU
    branch_case(3'b110, 5'd25, 5'd26, 8, 1'b0);
    branch_case(3'b111, 5'd25, 5'd26, 9, 1'b1);   // BGEU
    branch_case(3'b111, 5'd26, 5'd25, 10, 1'b0);
    p = cur_pc();
    prog.push_back(enc_j(5'd29, 12));
    prog.push_back(enc_sw(5'd0, JUNK_ADDR[11:0]));
    prog.push_back(enc_sw(5'd0, JUNK_ADDR[11:0]));
    store_expect(5'd29, p + 4);
    p = cur_pc();
    prog.push_back(enc_u(OPC_AUIPC, 5'd30, 20'h0));
    prog.push_back(enc_i(OPC_JALR, 3'b000, 5'd31, 5'd30, 17));   // Bit 0 cleared
    prog.push_back(enc_sw(5'd0, JUNK_ADDR[11:0]));
    prog.push_back(enc_sw(5'd0, JUNK_ADDR[11:0]));
    store_expect(5'd31, p + 8);
    prog.push_back(enc_u(OPC_LUI, 5'd6, 20'ha5a5a));
    prog.push_back(enc_i(OPC_OPIMM, 3'b000, 5'd6, 5'd6, 32'h5a5));
    p = saddr;
    store_expect(5'd6, 32'ha5a5_a5a5);
    prog.push_back(enc_i(OPC_LOAD, 3'b010, 5'd7, 5'd0, p));
    prog.push_back(NOP_INSTR);                                      // Load spacer
    store_expect(5'd7, 32'ha5a5_a5a5);
    prog.push_back(enc_i(OPC_LOAD, 3'b010, 5'd8, 5'd0, 32'h3c0));
    prog.push_back(NOP_INSTR);
    store_expect(5'd8, fill_word(32'h3c0));
    prog.push_back(enc_j(5'd0, 0));                                 // Park here
  endtask

  always @(negedge clk) begin
    smp_ready = mem_ready;
    smp_wr    = dmem_wr_en;
    smp_rd    = dmem_rd_en;
    smp_iaddr = imem_addr;
    smp_daddr = dmem_addr;
    smp_wdata = dmem_wdata;
  end

  always @(posedge clk) begin
    #2;
    if (arst_n && smp_ready) begin
      imem_rdata = imem[smp_iaddr[9:2]];
      if (smp_rd) dmem_rdata = dmem[smp_daddr[9:2]];  // Read data only on a read strobe
      if (smp_wr) dmem[smp_daddr[9:2]] = smp_wdata;
    end
    mem_ready = arst_n ? (($random(seed) & 3) != 0) : 1'b1;  // Low about 1 in 4
    if (cycles == RESET_CYCLES) arst_n = 1'b1;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles > limit) begin
      $display("Timeout after %0d cycles waiting for the expected stores", cycles);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  initial begin
    build_program();
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : NOP_INSTR;
      dmem[i] = fill_word(i * 4);
    end
    limit = 8 * prog.size() * exp_q.size() + RESET_CYCLES;
    for (int k = 0; k < exp_q.size(); k++) begin
      do @(negedge clk); while (!(arst_n && dmem_wr_en && mem_ready));
      check_value("dmem_addr", dmem_addr, exp_q[k].addr);
      check_value("dmem_wdata", dmem_wdata, exp_q[k].data);
      @(posedge clk);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule : tb_riscv_core

`default_nettype wire

// ==== verilog.f ====
core_pkg.sv
if_stage.sv
reg_file.sv
id_stage.sv
ex_stage.sv
mem_wb_stage.sv
riscv_core.sv
riscv_core_sva.sv
tb_riscv_core.sv

// ==== Makefile ====
# Verilator build and run for the RV32I core testbench
VERILATOR ?= verilator
TOP       ?= tb_riscv_core
RTL_TOP   ?= riscv_core
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
